/* compile.f */
+incdir+hdl
hdl/i3c_lite_pkg.sv
hdl/desc_fifo.sv
hdl/i3c_csr_regs.sv
hdl/i3c_bus_engine.sv
hdl/i3c_lite.sv
verif/i3c_lite_assert.sv
verif/i3c_lite_tb.sv

/* verif/i3c_lite_tb.sv */
// Directed testbench for the I3C lite controller with an open-drain target model; run i3c_lite_tb
`timescale 1ns/1ps
`include "i3c_lite_params.svh"

module i3c_lite_tb;
  import i3c_lite_pkg::*;

  localparam logic [6:0] TGT_ADDR   = 7'h2a;
  localparam logic [6:0] OTHER_ADDR = 7'h13;
  localparam int HS_TIMEOUT = 100;
  localparam int POLL_LIMIT = 2000;

  // Target model phases
  localparam int P_IDLE  = 0;
  localparam int P_ADDR  = 1;
  localparam int P_AACK  = 2;
  localparam int P_WDATA = 3;
  localparam int P_WACK  = 4;
  localparam int P_RDATA = 5;
  localparam int P_WAIT  = 6;

  logic       clk;
  logic       rst_n;
  csr_req_t   req;
  logic       req_valid;
  logic       req_ready;
  csr_rsp_t   rsp;
  logic       rsp_valid;
  logic       rsp_ready;
  logic       scl_en;
  logic       sda_en;
  logic       scl_line;
  logic       sda_line;

  logic        tgt_pull;
  logic        nack_data;
  logic [31:0] rng_state;
  logic [7:0]  wr_log[$];
  int          tgt_phase;
  int          tgt_bits;
  logic [7:0]  tgt_shift;
  logic [7:0]  tgt_rd_byte;
  logic        tgt_rnw;
  logic        scl_prev;
  logic        sda_prev;

  int errors;
  int checks;

  // Open-drain lines as a wired-AND of the pull-downs
  // SCL has no pull-down but the DUT's
  assign scl_line = !scl_en;
  assign sda_line = !(sda_en || tgt_pull);

  i3c_lite UUT (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .req_i       (req),
    .req_valid_i (req_valid),
    .req_ready_o (req_ready),
    .rsp_o       (rsp),
    .rsp_valid_o (rsp_valid),
    .rsp_ready_i (rsp_ready),
    .sda_i       (sda_line),
    .scl_en_o    (scl_en),
    .sda_en_o    (sda_en)
  );

  bind i3c_lite i3c_lite_assert u_assert (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .req_ready_i  (req_ready_o),
    .rsp_i        (rsp_o),
    .rsp_valid_i  (rsp_valid_o),
    .rsp_ready_i  (rsp_ready_i),
    .scl_en_i     (scl_en_o),
    .sda_en_i     (sda_en_o),
    .cmd_pop_i    (u_cmd_fifo.pop),
    .resp_pop_i   (u_resp_fifo.pop),
    .cmd_count_i  (u_cmd_fifo.count),
    .resp_count_i (u_resp_fifo.count)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = !clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Target acts on the falling edge between DUT clock edges
  always @(negedge clk) begin
    logic scl_now;
    logic sda_now;
    scl_now = scl_line;
    sda_now = sda_line;
    if (rst_n) begin
      if (scl_prev && scl_now && sda_prev && !sda_now) begin
        tgt_phase = P_ADDR;
        tgt_bits  = 0;
        tgt_pull  = 1'b0;
      end else if (scl_prev && scl_now && !sda_prev && sda_now) begin
        tgt_phase = P_IDLE;
        tgt_pull  = 1'b0;
      end else if (!scl_prev && scl_now) begin
        if (tgt_phase == P_ADDR || tgt_phase == P_WDATA) begin
          tgt_shift = {tgt_shift[6:0], sda_now};
          tgt_bits++;
        end
      end else if (scl_prev && !scl_now) begin
        case (tgt_phase)
          P_ADDR: begin
            if (tgt_bits == 8 && tgt_shift[7:1] == TGT_ADDR) begin
              tgt_pull  = 1'b1;
              tgt_rnw   = tgt_shift[0];
              tgt_phase = P_AACK;
            end else if (tgt_bits == 8) begin
              tgt_phase = P_WAIT;
            end
          end
          P_AACK: begin
            if (tgt_rnw) begin
              rng_state   = xorshift32(rng_state);
              tgt_rd_byte = rng_state[7:0];
              tgt_pull    = !tgt_rd_byte[7];
              tgt_bits    = 1;
              tgt_phase   = P_RDATA;
            end else begin
              tgt_pull  = 1'b0;
              tgt_bits  = 0;
              tgt_phase = P_WDATA;
            end
          end
          P_WDATA: begin
            if (tgt_bits == 8) begin
              wr_log.push_back(tgt_shift);
              tgt_pull  = !nack_data;
              tgt_phase = P_WACK;
            end
          end
          P_WACK: begin
            tgt_pull  = 1'b0;
            tgt_phase = P_WAIT;
          end
          P_RDATA: begin
            // Released after bit 0 so the controller can NACK
            if (tgt_bits == 8) begin
              tgt_pull  = 1'b0;
              tgt_phase = P_WAIT;
            end else begin
              tgt_pull = !tgt_rd_byte[7 - tgt_bits];
              tgt_bits++;
            end
          end
          default: ;
        endcase
      end
    end
    scl_prev = scl_now;
    sda_prev = sda_now;
  end

  task automatic abort_run(input string what);
    $display("Timeout at %0t: %s", $time, what);
    $display("Simulation failed");
    $finish;
  endtask

  // Called on a falling edge and returns on one
  task automatic csr_access(input logic wr, input logic [`CSR_AW-1:0] addr,
                            input logic [`CSR_DW-1:0] wdata, output csr_rsp_t got);
    int n;
    req       = '{wr: wr, addr: addr, wdata: wdata};
    req_valid = 1'b1;
    n = 0;
    while (!req_ready) begin
      @(negedge clk);
      n++;
      if (n > HS_TIMEOUT) abort_run("CSR request never accepted");
    end
    @(negedge clk);
    req_valid = 1'b0;
    n = 0;
    while (!rsp_valid) begin
      @(negedge clk);
      n++;
      if (n > HS_TIMEOUT) abort_run("CSR response never arrived");
    end
    // Host stalls one cycle before it takes the response
    @(negedge clk);
    got       = rsp;
    rsp_ready = 1'b1;
    @(negedge clk);
    rsp_ready = 1'b0;
  endtask

  task automatic csr_write(input logic [`CSR_AW-1:0] addr, input logic [`CSR_DW-1:0] wdata,
                           output csr_rsp_t got);
    csr_access(1'b1, addr, wdata, got);
  endtask

  task automatic csr_read(input logic [`CSR_AW-1:0] addr, output csr_rsp_t got);
    csr_access(1'b0, addr, '0, got);
  endtask

  function automatic csr_rsp_t ok_rsp(input logic [`CSR_DW-1:0] data);
    csr_rsp_t r;
    r.rdata = data;
    r.err   = 1'b0;
    return r;
  endfunction

  function automatic csr_rsp_t err_rsp();
    csr_rsp_t r;
    r.rdata = '0;
    r.err   = 1'b1;
    return r;
  endfunction

  function automatic logic [`CSR_DW-1:0] status_word(input logic cmd_empty, input logic cmd_full,
      input logic resp_empty, input logic resp_full, input logic idle);
    logic [`CSR_DW-1:0] w;
    w    = '0;
    w[0] = cmd_empty;
    w[1] = cmd_full;
    w[2] = resp_empty;
    w[3] = resp_full;
    w[4] = idle;
    return w;
  endfunction

  function automatic cmd_desc_u write_cmd(input logic [3:0] tid, input logic [6:0] addr,
                                          input logic [7:0] data);
    cmd_desc_u c;
    c.imm.attr = ATTR_IMM_WRITE;
    c.imm.tid  = tid;
    c.imm.addr = addr;
    c.imm.rsvd = '0;
    c.imm.data = data;
    return c;
  endfunction

  function automatic cmd_desc_u read_cmd(input logic [3:0] tid, input logic [6:0] addr);
    cmd_desc_u c;
    c.rd.attr = ATTR_READ;
    c.rd.tid  = tid;
    c.rd.addr = addr;
    c.rd.rsvd = '0;
    return c;
  endfunction

  function automatic resp_desc_t exp_desc(input logic [3:0] tid, input resp_status_e st,
                                          input logic [7:0] data);
    resp_desc_t d;
    d.tid    = tid;
    d.status = st;
    d.rsvd   = '0;
    d.data   = data;
    return d;
  endfunction

  task automatic check_rsp(input csr_rsp_t got, input csr_rsp_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t: %s, got rdata %h err %b, expected rdata %h err %b",
               $time, what, got.rdata, got.err, exp.rdata, exp.err);
    end
  endtask

  task automatic check_resp_desc(input resp_desc_t got, input resp_desc_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t: %s, got tid %h status %0d data %h, expected tid %h status %0d data %h",
               $time, what, got.tid, got.status, got.data, exp.tid, exp.status, exp.data);
    end
  endtask

  task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_log_size(input int n, input string what);
    checks++;
    if (wr_log.size() != n) begin
      errors++;
      $display("Fail at %0t: %s, target logged %0d bytes, expected %0d",
               $time, what, wr_log.size(), n);
    end
  endtask

  // Poll STATUS until a response waits in the queue
  task automatic wait_response();
    csr_rsp_t st;
    int n;
    n = 0;
    csr_read(`REG_STATUS, st);
    while (st.rdata[2]) begin
      n++;
      if (n > POLL_LIMIT) abort_run("no response descriptor arrived");
      csr_read(`REG_STATUS, st);
    end
  endtask

  task automatic pop_resp(output resp_desc_t d);
    csr_rsp_t r;
    csr_read(`REG_RESP_PORT, r);
    checks++;
    if (r.err) begin
      errors++;
      $display("Fail at %0t: RESP_PORT read answered err", $time);
    end
    d = resp_desc_t'(r.rdata);
  endtask

  task automatic run_cmd(input cmd_desc_u c, output resp_desc_t d);
    csr_rsp_t r;
    csr_write(`REG_CMD_PORT, c, r);
    check_rsp(r, ok_rsp('0), "command push");
    wait_response();
    pop_resp(d);
  endtask

  task automatic end_test(input string name, input int err0);
    $display("Test %s done at %0t, %0d errors", name, $time, errors - err0);
  endtask

  task automatic test_reset_state();
    csr_rsp_t r;
    int err0;
    err0 = errors;
    csr_read(`REG_CTRL, r);
    check_rsp(r, ok_rsp('0), "CTRL after reset");
    csr_read(`REG_T_LOW, r);
    check_rsp(r, ok_rsp(`T_LOW_RST), "T_LOW after reset");
    csr_read(`REG_T_HIGH, r);
    check_rsp(r, ok_rsp(`T_HIGH_RST), "T_HIGH after reset");
    csr_read(`REG_STATUS, r);
    check_rsp(r, ok_rsp(status_word(1'b1, 1'b0, 1'b1, 1'b0, 1'b1)), "STATUS after reset");
    end_test("reset_state", err0);
  endtask

  task automatic test_registers();
    csr_rsp_t r;
    int err0;
    err0 = errors;
    // Odd SCL high time moves the sample point off centre
    csr_write(`REG_T_LOW, 32'd6, r);
    check_rsp(r, ok_rsp('0), "T_LOW write");
    csr_write(`REG_T_HIGH, 32'd5, r);
    check_rsp(r, ok_rsp('0), "T_HIGH write");
    csr_read(`REG_T_LOW, r);
    check_rsp(r, ok_rsp(32'd6), "T_LOW readback");
    csr_read(`REG_T_HIGH, r);
    check_rsp(r, ok_rsp(32'd5), "T_HIGH readback");
    csr_write(4'hc, 32'hffff_ffff, r);
    check_rsp(r, err_rsp(), "unmapped write");
    csr_read(4'hc, r);
    check_rsp(r, err_rsp(), "unmapped read");
    csr_read(`REG_RESP_PORT, r);
    check_rsp(r, err_rsp(), "RESP_PORT read while empty");
    csr_write(`REG_STATUS, 32'h1f, r);
    check_rsp(r, err_rsp(), "STATUS write");
    csr_read(`REG_STATUS, r);
    check_rsp(r, ok_rsp(status_word(1'b1, 1'b0, 1'b1, 1'b0, 1'b1)), "STATUS after bad writes");
    end_test("registers", err0);
  endtask

  task automatic test_imm_write();
    csr_rsp_t   r;
    resp_desc_t d;
    int err0;
    err0 = errors;
    wr_log.delete();
    csr_write(`REG_CTRL, 32'd1, r);
    check_rsp(r, ok_rsp('0), "CTRL enable");
    run_cmd(write_cmd(4'h1, TGT_ADDR, 8'ha5), d);
    check_resp_desc(d, exp_desc(4'h1, ST_OK, 8'h00), "immediate write response");
    check_log_size(1, "immediate write");
    if (wr_log.size() == 1) check_byte(wr_log[0], 8'ha5, "byte seen by target");
    nack_data = 1'b1;
    run_cmd(write_cmd(4'h2, TGT_ADDR, 8'h3c), d);
    check_resp_desc(d, exp_desc(4'h2, ST_DATA_NACK, 8'h00), "data NACK response");
    nack_data = 1'b0;
    end_test("imm_write", err0);
  endtask

  task automatic test_read();
    resp_desc_t  d;
    logic [31:0] next_state;
    int err0;
    err0 = errors;
    // Byte the target will return next
    next_state = xorshift32(rng_state);
    run_cmd(read_cmd(4'h3, TGT_ADDR), d);
    check_resp_desc(d, exp_desc(4'h3, ST_OK, next_state[7:0]), "read response");
    end_test("read", err0);
  endtask

  task automatic test_addr_nack();
    resp_desc_t d;
    int err0;
    err0 = errors;
    wr_log.delete();
    run_cmd(write_cmd(4'h4, OTHER_ADDR, 8'h77), d);
    check_resp_desc(d, exp_desc(4'h4, ST_ADDR_NACK, 8'h00), "address NACK response");
    check_log_size(0, "address NACK");
    end_test("addr_nack", err0);
  endtask

  task automatic test_queue_limits();
    csr_rsp_t   r;
    resp_desc_t d;
    int n;
    int err0;
    err0 = errors;
    wr_log.delete();
    csr_write(`REG_CTRL, 32'd0, r);
    check_rsp(r, ok_rsp('0), "CTRL disable");
    for (int i = 0; i < `CMD_DEPTH; i++) begin
      csr_write(`REG_CMD_PORT, write_cmd(4'h8 + i[3:0], TGT_ADDR, 8'h10 + i[7:0]), r);
      check_rsp(r, ok_rsp('0), "queued command push");
    end
    csr_write(`REG_CMD_PORT, write_cmd(4'hf, TGT_ADDR, 8'hee), r);
    check_rsp(r, err_rsp(), "push into full command queue");
    csr_read(`REG_STATUS, r);
    check_rsp(r, ok_rsp(status_word(1'b0, 1'b1, 1'b1, 1'b0, 1'b1)), "STATUS with full queue");
    csr_write(`REG_CTRL, 32'd1, r);
    check_rsp(r, ok_rsp('0), "CTRL enable");
    n = 0;
    csr_read(`REG_STATUS, r);
    while (!(r.rdata[4] && r.rdata[0])) begin
      n++;
      if (n > POLL_LIMIT) abort_run("engine did not drain the command queue");
      csr_read(`REG_STATUS, r);
    end
    for (int i = 0; i < `CMD_DEPTH; i++) begin
      pop_resp(d);
      check_resp_desc(d, exp_desc(4'h8 + i[3:0], ST_OK, 8'h00), "queued response");
    end
    check_log_size(`CMD_DEPTH, "queued writes");
    if (wr_log.size() == `CMD_DEPTH) begin
      for (int i = 0; i < `CMD_DEPTH; i++) begin
        check_byte(wr_log[i], 8'h10 + i[7:0], "queued byte seen by target");
      end
    end
    end_test("queue_limits", err0);
  endtask

  initial begin
    req         = '0;
    req_valid   = 1'b0;
    rsp_ready   = 1'b0;
    rst_n       = 1'b0;
    tgt_pull    = 1'b0;
    nack_data   = 1'b0;
    rng_state   = 32'hed08_6549;
    tgt_phase   = P_IDLE;
    tgt_bits    = 0;
    tgt_shift   = '0;
    tgt_rd_byte = '0;
    tgt_rnw     = 1'b0;
    scl_prev    = 1'b1;
    sda_prev    = 1'b1;
    errors      = 0;
    checks      = 0;
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    test_reset_state();
    test_registers();
    test_imm_write();
    test_read();
    test_addr_nack();
    test_queue_limits();
    $display("Checks run %0d, errors %0d, assertion failures %0d",
             checks, errors, UUT.u_assert.fail_count);
    if (errors == 0 && UUT.u_assert.fail_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* verif/i3c_lite_assert.sv */
// Concurrent checks on the CSR handshake, queue occupancy and pad release; bound into i3c_lite
`timescale 1ns/1ps
`include "i3c_lite_params.svh"

module i3c_lite_assert (
  input logic                               clk_i,
  input logic                               rst_n_i,
  input logic                               req_ready_i,
  input i3c_lite_pkg::csr_rsp_t             rsp_i,
  input logic                               rsp_valid_i,
  input logic                               rsp_ready_i,
  input logic                               scl_en_i,
  input logic                               sda_en_i,
  input logic                               cmd_pop_i,
  input logic                               resp_pop_i,
  input logic [$clog2(`CMD_DEPTH):0]        cmd_count_i,
  input logic [$clog2(`RESP_DEPTH):0]       resp_count_i
);

  // Number of assertion failures so far
  int fail_count = 0;

  // Pending response held until the host takes it
  a_rsp_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (rsp_valid_i && !rsp_ready_i) |=> (rsp_valid_i && $stable(rsp_i)))
    else begin
      fail_count++;
      $error("CSR response changed or dropped before the host took it");
    end

  a_one_in_flight: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rsp_valid_i |-> !req_ready_i)
    else begin
      fail_count++;
      $error("New CSR request offered while a response is pending");
    end

  // A full queue stays full until a pop
  a_cmd_full_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ((cmd_count_i == `CMD_DEPTH) && !cmd_pop_i) |=> (cmd_count_i == `CMD_DEPTH))
    else begin
      fail_count++;
      $error("Command queue took a push while full");
    end

  a_resp_full_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ((resp_count_i == `RESP_DEPTH) && !resp_pop_i) |=> (resp_count_i == `RESP_DEPTH))
    else begin
      fail_count++;
      $error("Response queue took a push while full");
    end

  // Bus released right after reset
  a_reset_release: assert property (@(posedge clk_i)
    $rose(rst_n_i) |-> (!scl_en_i && !sda_en_i))
    else begin
      fail_count++;
      $error("SCL or SDA pulled low one cycle after reset");
    end

endmodule

/* hdl/i3c_lite.sv */
// Top of the I3C/I2C lite controller; connect a CSR host port and the open-drain SCL/SDA pads
`timescale 1ns/1ps
`include "i3c_lite_params.svh"

module i3c_lite (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  i3c_lite_pkg::csr_req_t req_i,
  input  logic                   req_valid_i,
  output logic                   req_ready_o,
  output i3c_lite_pkg::csr_rsp_t rsp_o,
  output logic                   rsp_valid_o,
  input  logic                   rsp_ready_i,
  input  logic                   sda_i,
  output logic                   scl_en_o,
  output logic                   sda_en_o
);
  import i3c_lite_pkg::*;

  // Command queue, register block to engine
  cmd_desc_u  cmd_push_data;
  logic       cmd_push_valid;
  logic       cmd_push_ready;
  logic       cmd_empty;
  cmd_desc_u  cmd_pop_data;
  logic       cmd_pop_valid;
  logic       cmd_pop_ready;

  // Response queue, engine to register block
  resp_desc_t resp_push_data;
  logic       resp_push_valid;
  logic       resp_push_ready;
  resp_desc_t resp_pop_data;
  logic       resp_pop_valid;
  logic       resp_pop_ready;
  logic       resp_full;

  logic       eng_en;
  timing_t    eng_timing;
  logic       eng_idle;

  i3c_csr_regs u_csr_regs (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .req_i         (req_i),
    .req_valid_i   (req_valid_i),
    .req_ready_o   (req_ready_o),
    .rsp_o         (rsp_o),
    .rsp_valid_o   (rsp_valid_o),
    .rsp_ready_i   (rsp_ready_i),
    .cmd_o         (cmd_push_data),
    .cmd_valid_o   (cmd_push_valid),
    .cmd_ready_i   (cmd_push_ready),
    .cmd_empty_i   (cmd_empty),
    .resp_i        (resp_pop_data),
    .resp_valid_i  (resp_pop_valid),
    .resp_ready_o  (resp_pop_ready),
    .resp_full_i   (resp_full),
    .en_o          (eng_en),
    .timing_o      (eng_timing),
    .engine_idle_i (eng_idle)
  );

  desc_fifo #(
    .WIDTH ($bits(cmd_desc_u)),
    .DEPTH (`CMD_DEPTH)
  ) u_cmd_fifo (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .wdata_i  (cmd_push_data),
    .wvalid_i (cmd_push_valid),
    .wready_o (cmd_push_ready),
    .rdata_o  (cmd_pop_data),
    .rvalid_o (cmd_pop_valid),
    .rready_i (cmd_pop_ready),
    .empty_o  (cmd_empty),
    .full_o   ()
  );

  desc_fifo #(
    .WIDTH ($bits(resp_desc_t)),
    .DEPTH (`RESP_DEPTH)
  ) u_resp_fifo (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .wdata_i  (resp_push_data),
    .wvalid_i (resp_push_valid),
    .wready_o (resp_push_ready),
    .rdata_o  (resp_pop_data),
    .rvalid_o (resp_pop_valid),
    .rready_i (resp_pop_ready),
    .empty_o  (),
    .full_o   (resp_full)
  );

  i3c_bus_engine u_bus_engine (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .en_i         (eng_en),
    .timing_i     (eng_timing),
    .cmd_i        (cmd_pop_data),
    .cmd_valid_i  (cmd_pop_valid),
    .cmd_ready_o  (cmd_pop_ready),
    .resp_o       (resp_push_data),
    .resp_valid_o (resp_push_valid),
    .resp_ready_i (resp_push_ready),
    .idle_o       (eng_idle),
    .sda_i        (sda_i),
    .scl_en_o     (scl_en_o),
    .sda_en_o     (sda_en_o)
  );

endmodule

/* hdl/i3c_bus_engine.sv */
// Bus engine of the I3C lite controller; runs one open-drain private transfer per command
`timescale 1ns/1ps
`include "i3c_lite_params.svh"

module i3c_bus_engine (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     en_i,
  input  i3c_lite_pkg::timing_t    timing_i,
  input  i3c_lite_pkg::cmd_desc_u  cmd_i,
  input  logic                     cmd_valid_i,
  output logic                     cmd_ready_o,
  output i3c_lite_pkg::resp_desc_t resp_o,
  output logic                     resp_valid_o,
  input  logic                     resp_ready_i,
  output logic                     idle_o,
  input  logic                     sda_i,
  output logic                     scl_en_o,
  output logic                     sda_en_o
);
  import i3c_lite_pkg::*;

  typedef enum logic [2:0] {
    S_IDLE,
    S_START,
    S_ADDR,
    S_ADDR_ACK,
    S_DATA,
    S_DATA_ACK,
    S_STOP,
    S_RESP
  } state_e;

  state_e               state_q;
  state_e               state_next;
  // Second half of a bit slot; SCL high in bit, ACK and STOP slots
  logic                 half_q;
  logic [`TIMING_W-1:0] cnt_q;
  logic [2:0]           bit_q;
  logic                 cmd_take;
  logic                 phase_end;
  logic                 sample_pt;
  logic                 bit_in;

  // Transfer payload
  logic [7:0]           shreg_q;
  logic [7:0]           wdata_q;
  logic [7:0]           rdata_q;
  logic [3:0]           tid_q;
  logic                 rnw_q;
  resp_status_e         status_q;
  logic                 sda_smp_q;

  logic                 scl_pull;
  logic                 sda_pull;
  logic                 sda_en_q;

  assign cmd_ready_o = (state_q == S_IDLE) && en_i;
  assign cmd_take    = cmd_valid_i && cmd_ready_o;
  assign phase_end   = (cnt_q == '0);
  // Middle of the SCL high phase
  assign sample_pt   = half_q && (cnt_q == (timing_i.t_high >> 1));
  assign bit_in      = sample_pt ? sda_i : sda_smp_q;

  always_comb begin
    case (state_q)
      S_START:    state_next = S_ADDR;
      S_ADDR:     state_next = (bit_q == 3'd0) ? S_ADDR_ACK : S_ADDR;
      S_ADDR_ACK: state_next = bit_in ? S_STOP : S_DATA;
      S_DATA:     state_next = (bit_q == 3'd0) ? S_DATA_ACK : S_DATA;
      S_DATA_ACK: state_next = S_STOP;
      S_STOP:     state_next = S_RESP;
      default:    state_next = state_q;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= S_IDLE;
      half_q  <= 1'b0;
      cnt_q   <= '0;
      bit_q   <= 3'd7;
    end else begin
      case (state_q)
        S_IDLE: begin
          // START spends both halves with SCL high
          if (cmd_take) begin
            state_q <= S_START;
            half_q  <= 1'b0;
            cnt_q   <= timing_i.t_high - 1'b1;
            bit_q   <= 3'd7;
          end
        end
        S_RESP: begin
          if (resp_ready_i) begin
            state_q <= S_IDLE;
          end
        end
        default: begin
          if (!phase_end) begin
            cnt_q <= cnt_q - 1'b1;
          end else if (!half_q) begin
            half_q <= 1'b1;
            cnt_q  <= timing_i.t_high - 1'b1;
          end else begin
            half_q  <= 1'b0;
            cnt_q   <= timing_i.t_low - 1'b1;
            state_q <= state_next;
            // Wraps back to 7 after the last bit of a byte
            if (state_q == S_ADDR || state_q == S_DATA) begin
              bit_q <= bit_q - 1'b1;
            end
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (sample_pt) begin
      sda_smp_q <= sda_i;
    end
    if (cmd_take) begin
      status_q <= ST_OK;
      rdata_q  <= '0;
      if (cmd_i.rd.attr == ATTR_READ) begin
        rnw_q   <= 1'b1;
        tid_q   <= cmd_i.rd.tid;
        shreg_q <= {cmd_i.rd.addr, 1'b1};
        wdata_q <= '0;
      end else begin
        rnw_q   <= 1'b0;
        tid_q   <= cmd_i.imm.tid;
        shreg_q <= {cmd_i.imm.addr, 1'b0};
        wdata_q <= cmd_i.imm.data;
      end
    end else if (half_q && phase_end) begin
      case (state_q)
        S_ADDR, S_DATA: shreg_q <= {shreg_q[6:0], bit_in};
        S_ADDR_ACK: begin
          shreg_q <= wdata_q;
          if (bit_in) begin
            status_q <= ST_ADDR_NACK;
          end
        end
        S_DATA_ACK: begin
          if (rnw_q) begin
            rdata_q <= shreg_q;
          end else if (bit_in) begin
            status_q <= ST_DATA_NACK;
          end
        end
        default: ;
      endcase
    end
  end

  // Pull-downs per state; ACK slots release SDA, which NACKs a read byte
  always_comb begin
    scl_pull = 1'b0;
    sda_pull = 1'b0;
    case (state_q)
      S_START: sda_pull = half_q;
      S_ADDR: begin
        scl_pull = !half_q;
        sda_pull = !shreg_q[7];
      end
      S_DATA: begin
        scl_pull = !half_q;
        sda_pull = !rnw_q && !shreg_q[7];
      end
      S_ADDR_ACK, S_DATA_ACK: scl_pull = !half_q;
      S_STOP: begin
        scl_pull = !half_q;
        sda_pull = 1'b1;
      end
      default: ;
    endcase
  end

  // SDA trails SCL by one clock so data never moves on an SCL edge
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sda_en_q <= 1'b0;
    end else begin
      sda_en_q <= sda_pull;
    end
  end

  assign scl_en_o     = scl_pull;
  assign sda_en_o     = sda_en_q;
  assign idle_o       = (state_q == S_IDLE);
  assign resp_valid_o = (state_q == S_RESP);
  assign resp_o       = '{tid: tid_q, status: status_q, rsvd: '0, data: rdata_q};

endmodule

/* hdl/i3c_csr_regs.sv */
// CSR block of the I3C lite controller; holds control and timing and moves queue descriptors
`timescale 1ns/1ps
`include "i3c_lite_params.svh"

module i3c_csr_regs (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  i3c_lite_pkg::csr_req_t   req_i,
  input  logic                     req_valid_i,
  output logic                     req_ready_o,
  output i3c_lite_pkg::csr_rsp_t   rsp_o,
  output logic                     rsp_valid_o,
  input  logic                     rsp_ready_i,
  output i3c_lite_pkg::cmd_desc_u  cmd_o,
  output logic                     cmd_valid_o,
  input  logic                     cmd_ready_i,
  input  logic                     cmd_empty_i,
  input  i3c_lite_pkg::resp_desc_t resp_i,
  input  logic                     resp_valid_i,
  output logic                     resp_ready_o,
  input  logic                     resp_full_i,
  output logic                     en_o,
  output i3c_lite_pkg::timing_t    timing_o,
  input  logic                     engine_idle_i
);
  import i3c_lite_pkg::*;

  logic               accept;
  logic               wr_acc;
  logic               rd_acc;
  logic [`CSR_DW-1:0] rd_data;
  logic               err;
  logic               en_q;
  timing_t            timing_q;
  csr_rsp_t           rsp_q;
  logic               rsp_valid_q;

  // One request in flight at a time
  assign req_ready_o = !rsp_valid_q;
  assign accept      = req_valid_i && req_ready_o;
  assign wr_acc      = accept && req_i.wr;
  assign rd_acc      = accept && !req_i.wr;

  // Command push only when the queue has room, so a full queue sees no valid
  assign cmd_o        = req_i.wdata;
  assign cmd_valid_o  = wr_acc && (req_i.addr == `REG_CMD_PORT) && cmd_ready_i;
  // Pop is harmless when the response queue is empty
  assign resp_ready_o = rd_acc && (req_i.addr == `REG_RESP_PORT);

  always_comb begin
    rd_data = '0;
    err     = 1'b0;
    case (req_i.addr)
      `REG_CTRL:   rd_data[0] = en_q;
      `REG_T_LOW:  rd_data[`TIMING_W-1:0] = timing_q.t_low;
      `REG_T_HIGH: rd_data[`TIMING_W-1:0] = timing_q.t_high;
      `REG_CMD_PORT: begin
        err = !req_i.wr || !cmd_ready_i;
      end
      `REG_RESP_PORT: begin
        err = req_i.wr || !resp_valid_i;
        if (!err) begin
          rd_data = resp_i;
        end
      end
      `REG_STATUS: begin
        err          = req_i.wr;
        rd_data[4:0] = {engine_idle_i, resp_full_i, !resp_valid_i, !cmd_ready_i, cmd_empty_i};
      end
      default: err = 1'b1;
    endcase
    // Write responses carry no data
    if (req_i.wr) begin
      rd_data = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      en_q            <= 1'b0;
      timing_q.t_low  <= `TIMING_W'(`T_LOW_RST);
      timing_q.t_high <= `TIMING_W'(`T_HIGH_RST);
    end else if (wr_acc) begin
      case (req_i.addr)
        `REG_CTRL:   en_q <= req_i.wdata[0];
        `REG_T_LOW:  timing_q.t_low <= req_i.wdata[`TIMING_W-1:0];
        `REG_T_HIGH: timing_q.t_high <= req_i.wdata[`TIMING_W-1:0];
        default: ;
      endcase
    end
  end

  // Response held until the host takes it
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_valid_q <= 1'b0;
    end else if (accept) begin
      rsp_valid_q <= 1'b1;
    end else if (rsp_ready_i) begin
      rsp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      rsp_q.rdata <= rd_data;
      rsp_q.err   <= err;
    end
  end

  assign rsp_o       = rsp_q;
  assign rsp_valid_o = rsp_valid_q;
  assign en_o        = en_q;
  assign timing_o    = timing_q;

endmodule

/* hdl/desc_fifo.sv */
// Synchronous descriptor FIFO with valid/ready on both sides; serves as command and response queue
`timescale 1ns/1ps

module desc_fifo #(
  parameter int WIDTH = 32,
  // Power of two, at least 2
  parameter int DEPTH = 4
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic [WIDTH-1:0] wdata_i,
  input  logic             wvalid_i,
  output logic             wready_o,
  output logic [WIDTH-1:0] rdata_o,
  output logic             rvalid_o,
  input  logic             rready_i,
  output logic             empty_o,
  output logic             full_o
);
  localparam int PTR_W = $clog2(DEPTH);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             push;
  logic             pop;

  assign full_o   = (count == (PTR_W + 1)'(DEPTH));
  assign empty_o  = (count == '0);
  assign wready_o = !full_o;
  assign rvalid_o = !empty_o;
  assign push     = wvalid_i && wready_o;
  assign pop      = rready_i && rvalid_o;
  assign rdata_o  = mem[rd_ptr];

  // Pointers wrap on their own since DEPTH is a power of two
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + {{PTR_W{1'b0}}, push} - {{PTR_W{1'b0}}, pop};
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wr_ptr] <= wdata_i;
    end
  end

endmodule

/* hdl/i3c_lite_pkg.sv */
// CSR, descriptor and timing types of the I3C lite controller; compile before the RTL modules
`include "i3c_lite_params.svh"

package i3c_lite_pkg;

  typedef struct packed {
    logic               wr;
    logic [`CSR_AW-1:0] addr;
    logic [`CSR_DW-1:0] wdata;
  } csr_req_t;

  typedef struct packed {
    logic [`CSR_DW-1:0] rdata;
    logic               err;
  } csr_rsp_t;

  typedef enum logic [1:0] {
    ATTR_IMM_WRITE = 2'd0,
    ATTR_READ      = 2'd1
  } cmd_attr_e;

  // Write of one byte carried in the descriptor itself
  typedef struct packed {
    cmd_attr_e   attr;
    logic [3:0]  tid;
    logic [6:0]  addr;
    logic [10:0] rsvd;
    logic [7:0]  data;
  } imm_write_desc_t;

  typedef struct packed {
    cmd_attr_e   attr;
    logic [3:0]  tid;
    logic [6:0]  addr;
    logic [18:0] rsvd;
  } read_desc_t;

  // attr sits at the top of both views and selects the one to use
  typedef union packed {
    imm_write_desc_t imm;
    read_desc_t      rd;
  } cmd_desc_u;

  typedef enum logic [1:0] {
    ST_OK        = 2'd0,
    ST_ADDR_NACK = 2'd1,
    ST_DATA_NACK = 2'd2
  } resp_status_e;

  typedef struct packed {
    logic [3:0]   tid;
    resp_status_e status;
    logic [17:0]  rsvd;
    logic [7:0]   data;
  } resp_desc_t;

  typedef struct packed {
    logic [`TIMING_W-1:0] t_low;
    logic [`TIMING_W-1:0] t_high;
  } timing_t;

endpackage

/* hdl/i3c_lite_params.svh */
// Widths, queue depths, CSR word map and SCL timing defaults; include wherever they are needed
`ifndef I3C_LITE_PARAMS_SVH
`define I3C_LITE_PARAMS_SVH

// CSR port geometry
`define CSR_AW 4
`define CSR_DW 32

// Queue depths, powers of two
`define CMD_DEPTH 4
`define RESP_DEPTH 4

// SCL phase counters, in system clocks
`define TIMING_W 16
`define T_LOW_RST 4
`define T_HIGH_RST 4

// CSR word addresses
`define REG_CTRL 4'h0
`define REG_T_LOW 4'h1
`define REG_T_HIGH 4'h2
`define REG_CMD_PORT 4'h3
`define REG_RESP_PORT 4'h4
`define REG_STATUS 4'h5

`endif
